// ==== usb_pkg.sv ====
/* Shared PID codes, line types and field constants for the USB full-speed
   transmitter, pulled into each block by a wildcard import */
package usb_pkg;

  // ********************
  // PID codes
  // ********************
  // PID code in the high nibble of the PID byte
  // Complement goes in the low nibble
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } pid_t;

  // Packet request sampled with start
  typedef struct packed {
    pid_t       pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } pkt_req_t;

  // Pin levels
  // oe is the d_mode output enable
  typedef struct packed {
    logic dp;
    logic dm;
    logic oe;
  } line_t;

  // Sequencer to stuffer and line driver
  typedef struct packed {
    logic active;
    logic se0;
  } line_cmd_t;

  // ********************
  // Field constants
  // ********************
  localparam logic [7:0]  SYNC_BYTE    = 8'h01;
  localparam logic [4:0]  CRC5_POLY    = 5'b00101;
  localparam logic [15:0] CRC16_POLY   = 16'h8005;
  // Ones in a row before a forced zero
  localparam int          STUFF_RUN    = 6;
  localparam int          EOP_SE0_BITS = 2;

endpackage

// ==== usb_crc_gen.sv ====
/* Serial CRC5/CRC16 generator, updated per sent bit and then shifted out
   inverted, MSB first, as the packet check field */
`timescale 1ns/1ps

module usb_crc_gen
  import usb_pkg::*;
(
  input  logic tb_clk,
  input  logic arst_n,
  input  logic crc_init,
  input  logic crc16_mode,
  input  logic crc_update,
  input  logic crc_shift,
  input  logic seq_bit,
  output logic crc_bit
);

  // CRC5 lives in the low 5 bits
  logic [15:0] crc;
  logic        top;
  logic        fb;

  assign top     = crc16_mode ? crc[15] : crc[4];
  assign fb      = seq_bit ^ top;
  // Check field goes out inverted
  assign crc_bit = ~top;

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc <= '1;
    end else if (crc_init) begin
      crc <= '1;
    end else if (crc_update) begin
      if (crc16_mode) crc <= {crc[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
      else crc[4:0] <= {crc[3:0], 1'b0} ^ (fb ? CRC5_POLY : 5'b00000);
    end else if (crc_shift) begin
      // Walk the remainder out past the top bit
      if (crc16_mode) crc <= {crc[14:0], 1'b1};
      else crc[4:0] <= {crc[3:0], 1'b1};
    end
  end

endmodule

// ==== usb_bit_stuffer.sv ====
/* Bit stuffer: counts consecutive ones and forces a zero after STUFF_RUN
   of them, holding the sequencer back for that bit period */
`timescale 1ns/1ps

module usb_bit_stuffer
  import usb_pkg::*;
(
  input  logic      tb_clk,
  input  logic      arst_n,
  input  line_cmd_t cmd,
  input  logic      bit_tick,
  input  logic      seq_bit,
  output logic      tx_bit,
  output logic      advance
);

  localparam int CNT_W = $clog2(STUFF_RUN + 1);

  logic [CNT_W-1:0] ones_cnt;
  logic             stuff;

  // No stuffing inside the SE0 part of the marker
  assign stuff   = cmd.active && !cmd.se0 && (ones_cnt == CNT_W'(STUFF_RUN));
  assign tx_bit  = stuff ? 1'b0 : seq_bit;
  // Stuffed period does not consume a sequencer bit
  assign advance = bit_tick && !stuff;

  // ********************
  // Run length of ones
  // ********************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      ones_cnt <= '0;
    end else if (!cmd.active) begin
      ones_cnt <= '0;
    end else if (bit_tick) begin
      if (stuff || cmd.se0 || !seq_bit) ones_cnt <= '0;
      else ones_cnt <= ones_cnt + CNT_W'(1);
    end
  end

endmodule

// ==== usb_line_driver.sv ====
/* Line driver: bit-period timer, NRZI encoder, SE0 and J of the end marker,
   and the output enable for the D+/D- pair */
`timescale 1ns/1ps

module usb_line_driver
  import usb_pkg::*;
#(
  parameter int clks_per_bit = 4
) (
  input  logic      tb_clk,
  input  logic      arst_n,
  input  line_cmd_t cmd,
  input  logic      tx_bit,
  output logic      bit_tick,
  output line_t     line
);

  localparam int    CNT_W     = $clog2(clks_per_bit);
  // Idle J, undriven
  localparam line_t LINE_IDLE = '{dp: 1'b1, dm: 1'b0, oe: 1'b0};

  logic [CNT_W-1:0] bit_cnt;
  logic             in_se0;
  // J period of the end marker is on the line
  logic             eop_j;

  // Tick in the first active cycle, then once per period
  assign bit_tick = cmd.active && (bit_cnt == '0);
  assign in_se0   = line.oe && !line.dp && !line.dm;

  // ********************
  // Timer and NRZI
  // ********************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
      line    <= LINE_IDLE;
      eop_j   <= 1'b0;
    end else if (!cmd.active) begin
      bit_cnt <= '0;
      line    <= LINE_IDLE;
      eop_j   <= 1'b0;
    end else begin
      if (bit_cnt == CNT_W'(clks_per_bit - 1)) bit_cnt <= '0;
      else bit_cnt <= bit_cnt + CNT_W'(1);
      if (bit_tick) begin
        if (eop_j) begin
          // End of the final J, release the bus
          line  <= LINE_IDLE;
          eop_j <= 1'b0;
        end else if (cmd.se0) begin
          line <= '{dp: 1'b0, dm: 1'b0, oe: 1'b1};
        end else if (in_se0) begin
          // Marker always closes with J
          line  <= '{dp: 1'b1, dm: 1'b0, oe: 1'b1};
          eop_j <= 1'b1;
        end else if (!tx_bit) begin
          // Zero toggles J/K
          line <= '{dp: ~line.dp, dm: line.dp, oe: 1'b1};
        end else begin
          line.oe <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== usb_pkt_sequencer.sv ====
/* Packet field FSM: serializes sync, PID, token or payload and CRC bits,
   then times the end-of-packet marker on raw bit ticks */
`timescale 1ns/1ps

module usb_pkt_sequencer
  import usb_pkg::*;
(
  input  logic       tb_clk,
  input  logic       arst_n,
  input  logic       start,
  input  pkt_req_t   req,
  input  logic [7:0] byte_data,
  input  logic       byte_last,
  output logic       byte_take,
  output logic       busy,
  input  logic       advance,
  input  logic       bit_tick,
  input  logic       crc_bit,
  output logic       seq_bit,
  output logic       seq_valid,
  output line_cmd_t  cmd,
  output logic       crc_init,
  output logic       crc16_mode,
  output logic       crc_update,
  output logic       crc_shift
);

  localparam int EOP_W = $clog2(EOP_SE0_BITS + 2);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SYNC,
    ST_PID,
    ST_TOKEN,
    ST_DATA,
    ST_CRC,
    ST_EOP
  } state_t;

  state_t           state;
  pkt_req_t         req_q;
  // Current field, MSB goes out first
  logic [10:0]      shreg;
  logic [3:0]       bit_cnt;
  logic [EOP_W-1:0] eop_cnt;
  logic             last_q;
  logic             is_token;
  logic             is_data;
  logic [3:0]       field_last;
  logic             field_done;

  // PID class
  always_comb begin
    is_token = 1'b0;
    is_data  = 1'b0;
    case (req_q.pid)
      PID_OUT, PID_IN:      is_token = 1'b1;
      PID_DATA0, PID_DATA1: is_data = 1'b1;
      default:              is_token = 1'b0;
    endcase
  end

  // Index of the final bit in the current field
  always_comb begin
    case (state)
      ST_TOKEN: field_last = 4'd10;
      ST_CRC:   field_last = crc16_mode ? 4'd15 : 4'd4;
      default:  field_last = 4'd7;
    endcase
  end

  assign field_done = advance && (bit_cnt == field_last);

  assign busy       = (state != ST_IDLE);
  assign cmd.active = busy;
  assign cmd.se0    = (state == ST_EOP) && (eop_cnt < EOP_W'(EOP_SE0_BITS));
  assign seq_valid  = busy && (state != ST_EOP);
  // Idle level is a one, CRC field comes straight from the generator
  assign seq_bit    = !seq_valid ? 1'b1 : ((state == ST_CRC) ? crc_bit : shreg[10]);

  assign crc_init   = start && !busy;
  assign crc16_mode = is_data;
  assign crc_update = advance && ((state == ST_TOKEN) || (state == ST_DATA));
  assign crc_shift  = advance && (state == ST_CRC);

  // First byte after the PID, then one per finished byte
  assign byte_take  = field_done &&
                      (((state == ST_PID) && is_data) || ((state == ST_DATA) && !last_q));

  // ********************
  // Field FSM
  // ********************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      eop_cnt <= '0;
      last_q  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE:  if (start) state <= ST_SYNC;
        ST_SYNC:  if (field_done) state <= ST_PID;
        ST_PID: begin
          if (field_done) begin
            if (is_token) state <= ST_TOKEN;
            else if (is_data) state <= ST_DATA;
            else state <= ST_EOP;
          end
        end
        ST_TOKEN: if (field_done) state <= ST_CRC;
        ST_DATA:  if (field_done && last_q) state <= ST_CRC;
        ST_CRC:   if (field_done) state <= ST_EOP;
        // SE0 periods, one J period, release on the tick after
        ST_EOP: begin
          if (bit_tick && (eop_cnt == EOP_W'(EOP_SE0_BITS + 1))) state <= ST_IDLE;
        end
        default:  state <= ST_IDLE;
      endcase
      if (!seq_valid || field_done) bit_cnt <= '0;
      else if (advance) bit_cnt <= bit_cnt + 4'd1;
      // Raw ticks, stuffing never applies here
      if (state != ST_EOP) eop_cnt <= '0;
      else if (bit_tick) eop_cnt <= eop_cnt + EOP_W'(1);
      if (byte_take) last_q <= byte_last;
    end
  end

  // Request and shift register, loaded per field
  always_ff @(posedge tb_clk) begin
    if ((state == ST_IDLE) && start) begin
      req_q <= req;
      shreg <= {SYNC_BYTE, 3'b000};
    end else if (field_done && (state == ST_SYNC)) begin
      shreg <= {req_q.pid, ~req_q.pid, 3'b000};
    end else if (field_done && (state == ST_PID) && is_token) begin
      shreg <= {req_q.addr, req_q.endp};
    end else if (byte_take) begin
      shreg <= {byte_data, 3'b000};
    end else if (advance) begin
      shreg <= {shreg[9:0], 1'b0};
    end
  end

endmodule

// ==== usb_tx_top.sv ====
/* Top level of the USB full-speed packet transmitter; wires the sequencer,
   CRC generator, bit stuffer and line driver and sets the bit period */
`timescale 1ns/1ps

module usb_tx_top
  import usb_pkg::*;
#(
  parameter int clks_per_bit = 4
) (
  input  logic       tb_clk,
  input  logic       arst_n,
  input  logic       start,
  input  pkt_req_t   req,
  input  logic [7:0] byte_data,
  input  logic       byte_last,
  output logic       byte_take,
  output logic       busy,
  output line_t      line
);

  logic      seq_bit;
  line_cmd_t cmd;
  logic      tx_bit;
  logic      advance;
  logic      bit_tick;
  logic      crc_bit;
  logic      crc_init;
  logic      crc16_mode;
  logic      crc_update;
  logic      crc_shift;

  // ********************
  // Field sequencing
  // ********************
  usb_pkt_sequencer u_seq (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .start      (start),
    .req        (req),
    .byte_data  (byte_data),
    .byte_last  (byte_last),
    .byte_take  (byte_take),
    .busy       (busy),
    .advance    (advance),
    .bit_tick   (bit_tick),
    .crc_bit    (crc_bit),
    .seq_bit    (seq_bit),
    .seq_valid  (),
    .cmd        (cmd),
    .crc_init   (crc_init),
    .crc16_mode (crc16_mode),
    .crc_update (crc_update),
    .crc_shift  (crc_shift)
  );

  usb_crc_gen u_crc (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .crc_init   (crc_init),
    .crc16_mode (crc16_mode),
    .crc_update (crc_update),
    .crc_shift  (crc_shift),
    .seq_bit    (seq_bit),
    .crc_bit    (crc_bit)
  );

  // ********************
  // Line side
  // ********************
  usb_bit_stuffer u_stuff (
    .tb_clk   (tb_clk),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .bit_tick (bit_tick),
    .seq_bit  (seq_bit),
    .tx_bit   (tx_bit),
    .advance  (advance)
  );

  usb_line_driver #(
    .clks_per_bit (clks_per_bit)
  ) u_drv (
    .tb_clk   (tb_clk),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .tx_bit   (tx_bit),
    .bit_tick (bit_tick),
    .line     (line)
  );

endmodule

// ==== tb_usb_model.svh ====
/* Testbench reference model, included inside the testbench module:
   LFSR stimulus, expected line levels per packet and the compare tasks */
`ifndef TB_USB_MODEL_SVH
`define TB_USB_MODEL_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Serial CRC over the bits as sent, MSB first
// Result comes back inverted
function automatic logic [15:0] model_crc(input logic bits[$], input int width,
                                          input logic [15:0] poly);
  logic [15:0] crc;
  logic        fb;
  crc = '1;
  foreach (bits[i]) begin
    fb  = bits[i] ^ crc[width-1];
    crc = crc << 1;
    if (fb) crc = crc ^ poly;
  end
  return ~crc;
endfunction

// ********************
// Expected line samples
// ********************
// Unstuffed bit list followed by stuffing, NRZI and the end marker
task automatic model_packet(input usb_pkg::pkt_req_t req, input logic [7:0] payload[$],
                            output usb_pkg::line_t exp[$], output int n_stuffed);
  logic        bits[$];
  logic        body[$];
  logic [10:0] tok;
  logic [15:0] crc;
  logic        lvl;
  int          ones;
  for (int i = 7; i >= 0; i--) bits.push_back(usb_pkg::SYNC_BYTE[i]);
  for (int i = 3; i >= 0; i--) bits.push_back(req.pid[i]);
  for (int i = 3; i >= 0; i--) bits.push_back(~req.pid[i]);
  tok = {req.addr, req.endp};
  if ((req.pid == usb_pkg::PID_OUT) || (req.pid == usb_pkg::PID_IN)) begin
    for (int i = 10; i >= 0; i--) body.push_back(tok[i]);
    crc = model_crc(body, 5, {11'd0, usb_pkg::CRC5_POLY});
    for (int i = 4; i >= 0; i--) body.push_back(crc[i]);
  end else if ((req.pid == usb_pkg::PID_DATA0) || (req.pid == usb_pkg::PID_DATA1)) begin
    foreach (payload[b]) begin
      for (int i = 7; i >= 0; i--) body.push_back(payload[b][i]);
    end
    crc = model_crc(body, 16, usb_pkg::CRC16_POLY);
    for (int i = 15; i >= 0; i--) body.push_back(crc[i]);
  end
  bits = {bits, body};
  exp = {};
  n_stuffed = 0;
  ones = 0;
  lvl = 1'b1;
  foreach (bits[i]) begin
    // Stuffed zero only ahead of a following bit
    if (ones == usb_pkg::STUFF_RUN) begin
      lvl = ~lvl;
      exp.push_back('{dp: lvl, dm: ~lvl, oe: 1'b1});
      n_stuffed++;
      ones = 0;
    end
    if (bits[i]) begin
      ones++;
    end else begin
      ones = 0;
      lvl = ~lvl;
    end
    exp.push_back('{dp: lvl, dm: ~lvl, oe: 1'b1});
  end
  repeat (usb_pkg::EOP_SE0_BITS) exp.push_back('{dp: 1'b0, dm: 1'b0, oe: 1'b1});
  exp.push_back('{dp: 1'b1, dm: 1'b0, oe: 1'b1});
endtask

// ********************
// Compare tasks
// ********************
task automatic check_line(input usb_pkg::line_t got, input usb_pkg::line_t want,
                          input int idx, ref int errs);
  if (got !== want) begin
    errs++;
    $display("Fail line at period %0d: got %h want %h", idx, got, want);
  end
endtask

task automatic check_length(input string name, input int got, input int want,
                            ref int errs);
  if (got != want) begin
    errs++;
    $display("Fail %s: got %0h want %0h", name, got, want);
  end
endtask

`endif

// ==== tb_usb_tx.sv ====
/* Testbench for the USB full-speed transmitter; random tokens, data and
   handshake packets checked line by line against the included model */
`timescale 1ns/1ps

module tb_usb_tx
  import usb_pkg::*;
();

  // Bit period in clocks
  localparam int CPB        = 4;
  localparam int N_TOKEN    = 12;
  localparam int N_DATA     = 12;
  localparam int N_FF       = 2;
  localparam int N_HS       = 3;
  // Worst-case periods per packet with stuffing
  localparam int TOKEN_MAX  = 40;
  localparam int DATA_MAX   = 190;
  localparam int HS_MAX     = 21;
  localparam int GAP        = 10;
  localparam int WORST_PERIODS = (N_TOKEN + 1) * (TOKEN_MAX + GAP)
                               + (N_DATA + N_FF) * (DATA_MAX + GAP)
                               + N_HS * (HS_MAX + GAP) + 2 * GAP;
  localparam int WATCH_NS   = WORST_PERIODS * CPB * 20 * 2;

  logic        tb_clk;
  logic        arst_n;
  logic        start;
  pkt_req_t    req;
  logic [7:0]  byte_data;
  logic        byte_last;
  logic        byte_take;
  logic        busy;
  line_t       line;

  logic [31:0] lfsr_state = 32'hb079_0672;
  line_t       got_q[$];
  int          oe_cycles;
  int          line_errs;
  int          len_errs;
  int          other_errs;

  `include "tb_usb_model.svh"

  usb_tx_top #(
    .clks_per_bit (CPB)
  ) dut (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .start     (start),
    .req       (req),
    .byte_data (byte_data),
    .byte_last (byte_last),
    .byte_take (byte_take),
    .busy      (busy),
    .line      (line)
  );

  initial begin
    tb_clk = 1'b0;
    forever #10 tb_clk = ~tb_clk;
  end

  // Safety net for a stuck packet
  initial begin
    #(WATCH_NS);
    $display("Watchdog expired before all packets were sent");
    $display("TB FAILED");
    $finish;
  end

  // ********************
  // Line sampler
  // ********************
  // One sample near the middle of each bit period
  initial begin
    int phase;
    phase = 0;
    forever begin
      @(negedge tb_clk);
      if (line.oe) begin
        oe_cycles++;
        if (phase == CPB / 2) got_q.push_back(line);
        phase = (phase == CPB - 1) ? 0 : phase + 1;
      end else begin
        phase = 0;
      end
    end
  end

  // n bits off the LFSR with one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic expect_count(input string name, input int got, input int want);
    if (got != want) begin
      other_errs++;
      $display("Fail %s: got %0h want %0h", name, got, want);
    end
  endtask

  task automatic expect_level(input string name, input logic got, input logic want);
    if (got !== want) begin
      other_errs++;
      $display("Fail %s: got %0h want %0h", name, got, want);
    end
  endtask

  // Bus must stay quiet with no start
  task automatic idle_gap();
    repeat (GAP * CPB) begin
      @(negedge tb_clk);
      if (busy || line.oe) begin
        other_errs++;
        $display("Transmitter became active without a start pulse");
        return;
      end
    end
  endtask

  // ********************
  // One packet from start to busy fall
  // ********************
  task automatic run_packet(input pkt_req_t r, input logic [7:0] payload[$],
                            input bit poke_start, output int n_stuffed);
    line_t exp[$];
    int    take_cnt;
    int    n_bytes;
    model_packet(r, payload, exp, n_stuffed);
    n_bytes   = payload.size();
    got_q     = {};
    oe_cycles = 0;
    take_cnt  = 0;
    @(negedge tb_clk);
    start = 1'b1;
    req   = r;
    if (n_bytes > 0) begin
      byte_data = payload[0];
      byte_last = (n_bytes == 1);
    end
    @(negedge tb_clk);
    start = 1'b0;
    if (!busy) begin
      other_errs++;
      $display("busy did not rise after the start pulse");
      return;
    end
    // Second start mid-packet is ignored
    if (poke_start) begin
      repeat (10 * CPB) @(negedge tb_clk);
      if (!busy) begin
        other_errs++;
        $display("Packet ended before the extra start could be given");
      end
      start = 1'b1;
      req   = '{pid: PID_DATA1, addr: 7'h55, endp: 4'h3};
      @(negedge tb_clk);
      start = 1'b0;
    end
    while (busy) begin
      if (byte_take) begin
        // Byte is taken at the next edge
        // Next byte follows right after it
        take_cnt++;
        @(negedge tb_clk);
        if (take_cnt < n_bytes) begin
          byte_data = payload[take_cnt];
          byte_last = (take_cnt == n_bytes - 1);
        end
      end else begin
        @(negedge tb_clk);
      end
    end
    check_length("line periods", got_q.size(), exp.size(), len_errs);
    check_length("oe clocks", oe_cycles, exp.size() * CPB, len_errs);
    foreach (got_q[i]) begin
      if (i < exp.size()) check_line(got_q[i], exp[i], i, line_errs);
    end
    expect_count("byte_take pulses", take_cnt, n_bytes);
    expect_level("line.oe", line.oe, 1'b0);
  endtask

  // ********************
  // Stimulus
  // ********************
  initial begin
    pkt_req_t   r;
    logic [7:0] pl[$];
    int         n_len;
    int         n_stuffed;
    int         plain_len;
    pid_t       hs[3];
    arst_n     = 1'b0;
    start      = 1'b0;
    req        = '{pid: PID_ACK, addr: 7'd0, endp: 4'd0};
    byte_data  = 8'h00;
    byte_last  = 1'b0;
    line_errs  = 0;
    len_errs   = 0;
    other_errs = 0;
    oe_cycles  = 0;
    repeat (5) @(posedge tb_clk);
    @(negedge tb_clk);
    arst_n = 1'b1;
    repeat (3) @(negedge tb_clk);

    // Idle J with the bus undriven
    check_line(line, '{dp: 1'b1, dm: 1'b0, oe: 1'b0}, -1, line_errs);
    expect_level("busy", busy, 1'b0);
    expect_level("byte_take", byte_take, 1'b0);

    // Tokens
    for (int k = 0; k < N_TOKEN; k++) begin
      r.pid  = rand_bits(1) ? PID_IN : PID_OUT;
      r.addr = 7'(rand_bits(7));
      r.endp = 4'(rand_bits(4));
      pl = {};
      run_packet(r, pl, 1'b0, n_stuffed);
      idle_gap();
    end

    // Data with random payload of 1 to 16 bytes
    for (int k = 0; k < N_DATA; k++) begin
      r.pid  = rand_bits(1) ? PID_DATA1 : PID_DATA0;
      r.addr = 7'd0;
      r.endp = 4'd0;
      n_len  = 1 + int'(rand_bits(4));
      pl = {};
      repeat (n_len) pl.push_back(8'(rand_bits(8)));
      run_packet(r, pl, 1'b0, n_stuffed);
      idle_gap();
    end

    // Long runs of ones force stuffing
    for (int k = 0; k < N_FF; k++) begin
      r.pid = (k == 0) ? PID_DATA0 : PID_DATA1;
      pl = {};
      repeat ((k == 0) ? 16 : 5) pl.push_back(8'hff);
      run_packet(r, pl, 1'b0, n_stuffed);
      // Sync, PID, payload, CRC16 and the three end marker periods
      plain_len = 8 * pl.size() + 35;
      check_length("stuffed periods", got_q.size(), plain_len + n_stuffed, len_errs);
      if (got_q.size() <= plain_len) begin
        other_errs++;
        $display("No stuffed bits appeared on the line for an all-ones payload");
      end
      idle_gap();
    end

    // Handshakes carry a PID only
    hs[0] = PID_ACK;
    hs[1] = PID_NAK;
    hs[2] = PID_STALL;
    for (int k = 0; k < N_HS; k++) begin
      r = '{pid: hs[k], addr: 7'd0, endp: 4'd0};
      pl = {};
      run_packet(r, pl, 1'b0, n_stuffed);
      idle_gap();
    end

    // Start while busy and no follow-up packet
    r = '{pid: PID_OUT, addr: 7'h2a, endp: 4'h9};
    pl = {};
    run_packet(r, pl, 1'b1, n_stuffed);
    idle_gap();

    $display("Errors: line %0d, length %0d, other %0d", line_errs, len_errs, other_errs);
    if ((line_errs + len_errs + other_errs) == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
usb_pkg.sv
usb_crc_gen.sv
usb_bit_stuffer.sv
usb_line_driver.sv
usb_pkt_sequencer.sv
usb_tx_top.sv
tb_usb_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the USB transmitter testbench with Verilator, runs it and
# decides pass or fail from the simulation log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_usb_tx -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" "$SIM_LOG"; then
  exit 0
fi
exit 1
